//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
FILE_LIST ?= compile.f
OBJ_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# A $fatal in the testbench makes the simulator exit with a failing status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+logic
logic/cpu_pkg.sv
logic/ram.sv
logic/alu.sv
logic/bus_arbiter.sv
logic/reg_file.sv
logic/sequencer.sv
logic/cpu.sv
tb/tb_clock.sv
tb/tb_cpu.sv

//--- logic/alu.sv
`include "cpu_params.svh"

module alu (
	input  cpu_pkg::byte_t i_a,
	input  cpu_pkg::byte_t i_b,
	input  cpu_pkg::byte_t i_op_byte,
	output cpu_pkg::byte_t o_result,
	output cpu_pkg::flags_t o_flags
);
	cpu_pkg::alu_op_t op;
	logic [`CPU_DATA_W:0] wide;
	logic known;

	always_comb begin
		op = cpu_pkg::alu_op_t'(i_op_byte[2:0]);
		// Bit 7 was the signed select, unsigned only here
		known = (i_op_byte[6:3] == '0);
		case (op)
			cpu_pkg::ADD: wide = {1'b0, i_a} + {1'b0, i_b};
			// Top bit of the difference is the borrow
			cpu_pkg::SUB: wide = {1'b0, i_a} - {1'b0, i_b};
			cpu_pkg::AND: wide = {1'b0, i_a & i_b};
			cpu_pkg::OR: wide = {1'b0, i_a | i_b};
			cpu_pkg::XOR: wide = {1'b0, i_a ^ i_b};
			cpu_pkg::PASS_B: wide = {1'b0, i_b};
			default: begin
				wide = '0;
				known = 1'b0;
			end
		endcase
		if (!known) wide = '0;

		o_result = wide[`CPU_DATA_W-1:0];
		o_flags = '0;
		o_flags.carry = wide[`CPU_DATA_W];
		o_flags.equal = (i_a == i_b);
		o_flags.less_than = (i_a < i_b);
		o_flags.zero = (o_result == '0);
		o_flags.undefined = !known;
	end

endmodule

//--- logic/bus_arbiter.sv
`include "cpu_params.svh"

module bus_arbiter (
	input  cpu_pkg::bus_sel_t i_sel,
	input  cpu_pkg::arch_state_t i_state,
	input  cpu_pkg::byte_t i_data_in,
	input  cpu_pkg::byte_t i_ram_word,
	output cpu_pkg::byte_t o_bus
);
	cpu_pkg::byte_t rip_next;

	// Next sequential byte after the instruction pointer
	assign rip_next = i_state.rip + 1'b1;

	always_comb begin
		case (i_sel)
			cpu_pkg::REG0, cpu_pkg::REG1, cpu_pkg::REG2, cpu_pkg::REG3,
			cpu_pkg::REG4, cpu_pkg::REG5, cpu_pkg::REG6, cpu_pkg::REG7: begin
				o_bus = i_state.regs[i_sel[2:0]];
			end
			cpu_pkg::D_IN: o_bus = i_data_in;
			cpu_pkg::RAX: o_bus = i_state.rax;
			cpu_pkg::RFL: o_bus = i_state.rfl;
			cpu_pkg::RAM: o_bus = i_ram_word;
			cpu_pkg::RIP: o_bus = i_state.rip;
			cpu_pkg::RIP_1: o_bus = rip_next;
			default: o_bus = '0;
		endcase
	end

	// Code 15 has no source and would silently read zero
	always_comb begin
		a_sel_valid: assert (i_sel !== {`CPU_SEL_W{1'b1}})
			else $error("bus_arbiter: select code 15 on the bus");
	end

endmodule

//--- logic/cpu.sv
module cpu (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_load_addr,
	input  logic i_load_data,
	input  logic i_execute,
	input  cpu_pkg::byte_t i_data_in,
	output cpu_pkg::byte_t o_data_out,
	output logic o_waiting
);
	cpu_pkg::ctrl_t ctrl;
	cpu_pkg::arch_state_t arch_state;
	cpu_pkg::addr_t mar;
	cpu_pkg::byte_t ram_word;
	cpu_pkg::byte_t bus;
	cpu_pkg::byte_t alu_result;
	cpu_pkg::flags_t alu_flags;

	// Memory view always shows the word at the address register
	assign o_data_out = ram_word;

	sequencer u_sequencer (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_load_addr(i_load_addr),
		.i_load_data(i_load_data),
		.i_execute(i_execute),
		.i_ram_word(ram_word),
		.i_flags(arch_state.rfl),
		.o_ctrl(ctrl),
		.o_waiting(o_waiting)
	);

	reg_file u_reg_file (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_ctrl(ctrl),
		.i_bus(bus),
		.i_alu_result(alu_result),
		.i_alu_flags(alu_flags),
		.o_state(arch_state),
		.o_mar(mar)
	);

	bus_arbiter u_bus_arbiter (
		.i_sel(ctrl.sel),
		.i_state(arch_state),
		.i_data_in(i_data_in),
		.i_ram_word(ram_word),
		.o_bus(bus)
	);

	// Accumulator against REG0, operation from the MATH operand
	alu u_alu (
		.i_a(arch_state.rax),
		.i_b(arch_state.regs[0]),
		.i_op_byte(ram_word),
		.o_result(alu_result),
		.o_flags(alu_flags)
	);

	ram u_ram (
		.i_clk(i_clk),
		.i_addr(mar),
		.i_wdata(bus),
		.i_write(ctrl.write_ram),
		.o_rdata(ram_word)
	);

endmodule

//--- logic/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data bus and memory address width
`define CPU_DATA_W 8

// General purpose registers REG0 to REG7
`define CPU_NUM_REGS 8

// Bus source select width, also the register code width in programs
`define CPU_SEL_W 4

// Step counter inside one sequencer state, saturates at all ones
`define CPU_CYCLE_W 3

// Words of program and data memory
`define CPU_MEM_DEPTH 256

`endif

//--- logic/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] byte_t;
	typedef logic [`CPU_DATA_W-1:0] addr_t;

	// Bus sources; the same codes name registers inside programs
	typedef enum logic [`CPU_SEL_W-1:0] {
		REG0 = 4'd0,
		REG1 = 4'd1,
		REG2 = 4'd2,
		REG3 = 4'd3,
		REG4 = 4'd4,
		REG5 = 4'd5,
		REG6 = 4'd6,
		REG7 = 4'd7,
		D_IN = 4'd8,
		RAX = 4'd9,
		RFL = 4'd10,
		RAM = 4'd11,
		RIP = 4'd12,
		RIP_1 = 4'd13,
		ZERO = 4'd14
	} bus_sel_t;

	typedef enum logic [4:0] {
		LOAD_ADDR,
		LOAD_ADDR_WAIT,
		LOAD_DATA,
		LOAD_DATA_WAIT,
		PRE_EXECUTE,
		FETCH,
		INC_RIP,
		EX_HALT,
		EX_NOOP,
		EX_JUMP,
		EX_MATH,
		EX_LDFM,
		EX_LDFI,
		EX_CPFR,
		EX_STOM,
		EX_JINZ,
		EX_JIEQ,
		EX_JILT,
		EX_JIGT
	} state_t;

	typedef enum logic [`CPU_DATA_W-1:0] {
		HALT = 8'h00,
		NOOP = 8'h01,
		JUMP = 8'h03,
		MATH = 8'h04,
		LDFM = 8'h05,
		LDFI = 8'h06,
		CPFR = 8'h08,
		STOM = 8'h09,
		JINZ = 8'h0a,
		JIEQ = 8'h0b,
		JILT = 8'h0c,
		JIGT = 8'h0d
	} opcode_t;

	// Low bits of the MATH operand byte
	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR = 3'd3,
		XOR = 3'd4,
		PASS_B = 3'd5
	} alu_op_t;

	typedef struct packed {
		logic carry;
		logic equal;
		logic less_than;
		logic zero;
		logic undefined;
		logic [2:0] spare;
	} flags_t;

	typedef struct packed {
		bus_sel_t sel;
		logic load_addr;
		logic load_rip;
		logic load_alu;
		logic load_rax;
		logic write_ram;
		logic [`CPU_NUM_REGS-1:0] load_reg;
	} ctrl_t;

	// Registers visible to programs
	typedef struct packed {
		byte_t [`CPU_NUM_REGS-1:0] regs;
		byte_t rax;
		flags_t rfl;
		byte_t rip;
	} arch_state_t;

endpackage

//--- logic/ram.sv
`include "cpu_params.svh"

module ram (
	input  logic i_clk,
	input  cpu_pkg::addr_t i_addr,
	input  cpu_pkg::byte_t i_wdata,
	input  logic i_write,
	output cpu_pkg::byte_t o_rdata
);
	cpu_pkg::byte_t mem [`CPU_MEM_DEPTH];

	// Read returns the old word when written in the same cycle
	always_ff @(posedge i_clk) begin
		if (i_write) mem[i_addr] <= i_wdata;
		o_rdata <= mem[i_addr];
	end

endmodule

//--- logic/reg_file.sv
`include "cpu_params.svh"

module reg_file (
	input  logic i_clk,
	input  logic i_reset,
	input  cpu_pkg::ctrl_t i_ctrl,
	input  cpu_pkg::byte_t i_bus,
	input  cpu_pkg::byte_t i_alu_result,
	input  cpu_pkg::flags_t i_alu_flags,
	output cpu_pkg::arch_state_t o_state,
	output cpu_pkg::addr_t o_mar
);
	logic rax_from_bus;
	logic rax_from_alu;

	assign rax_from_bus = i_ctrl.load_rax;
	assign rax_from_alu = i_ctrl.load_alu;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_state <= '0;
			o_mar <= '0;
		end else begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				if (i_ctrl.load_reg[i]) o_state.regs[i] <= i_bus;
			end
			if (rax_from_bus) o_state.rax <= i_bus;
			// MATH writes the accumulator and flags in the same edge
			if (rax_from_alu) begin
				o_state.rax <= i_alu_result;
				o_state.rfl <= i_alu_flags;
			end
			if (i_ctrl.load_rip) o_state.rip <= i_bus;
			// Address register feeds the RAM directly
			if (i_ctrl.load_addr) o_mar <= i_bus;
		end
	end

	a_rax_single_source: assert property (@(posedge i_clk) disable iff (i_reset)
		!(rax_from_bus && rax_from_alu))
		else $error("reg_file: RAX loaded from bus and ALU together");

endmodule

//--- logic/sequencer.sv
`include "cpu_params.svh"

module sequencer (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_load_addr,
	input  logic i_load_data,
	input  logic i_execute,
	input  cpu_pkg::byte_t i_ram_word,
	input  cpu_pkg::flags_t i_flags,
	output cpu_pkg::ctrl_t o_ctrl,
	output logic o_waiting
);
	cpu_pkg::state_t state;
	cpu_pkg::state_t next_state;
	logic [`CPU_CYCLE_W-1:0] step;
	cpu_pkg::byte_t reg_code;
	logic latch_code;
	logic load_target;
	logic jump_taken;

	function automatic cpu_pkg::state_t dispatch(cpu_pkg::byte_t opcode);
		case (opcode)
			cpu_pkg::NOOP: return cpu_pkg::EX_NOOP;
			cpu_pkg::JUMP: return cpu_pkg::EX_JUMP;
			cpu_pkg::MATH: return cpu_pkg::EX_MATH;
			cpu_pkg::LDFM: return cpu_pkg::EX_LDFM;
			cpu_pkg::LDFI: return cpu_pkg::EX_LDFI;
			cpu_pkg::CPFR: return cpu_pkg::EX_CPFR;
			cpu_pkg::STOM: return cpu_pkg::EX_STOM;
			cpu_pkg::JINZ: return cpu_pkg::EX_JINZ;
			cpu_pkg::JIEQ: return cpu_pkg::EX_JIEQ;
			cpu_pkg::JILT: return cpu_pkg::EX_JILT;
			cpu_pkg::JIGT: return cpu_pkg::EX_JIGT;
			// HALT and every unknown opcode
			default: return cpu_pkg::EX_HALT;
		endcase
	endfunction

	// Register codes beyond the bus sources read as zero
	function automatic cpu_pkg::bus_sel_t to_sel(cpu_pkg::byte_t code);
		if (code < 8'(cpu_pkg::ZERO)) begin
			return cpu_pkg::bus_sel_t'(code[`CPU_SEL_W-1:0]);
		end
		return cpu_pkg::ZERO;
	endfunction

	always_comb begin
		case (state)
			cpu_pkg::EX_JINZ: jump_taken = !i_flags.zero;
			cpu_pkg::EX_JIEQ: jump_taken = i_flags.equal;
			cpu_pkg::EX_JILT: jump_taken = i_flags.less_than;
			cpu_pkg::EX_JIGT: jump_taken = !(i_flags.equal || i_flags.less_than);
			default: jump_taken = 1'b0;
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			cpu_pkg::LOAD_ADDR: begin
				if (i_load_addr) begin
					next_state = cpu_pkg::LOAD_ADDR_WAIT;
				end else if (i_execute) begin
					next_state = cpu_pkg::PRE_EXECUTE;
				end
			end
			cpu_pkg::LOAD_ADDR_WAIT: if (!i_load_addr) next_state = cpu_pkg::LOAD_DATA;
			cpu_pkg::LOAD_DATA: if (i_load_data) next_state = cpu_pkg::LOAD_DATA_WAIT;
			cpu_pkg::LOAD_DATA_WAIT: if (!i_load_data) next_state = cpu_pkg::LOAD_ADDR;
			cpu_pkg::PRE_EXECUTE: if (!i_execute) next_state = cpu_pkg::FETCH;
			cpu_pkg::FETCH, cpu_pkg::INC_RIP: if (step == 2) next_state = dispatch(i_ram_word);
			cpu_pkg::EX_HALT: next_state = cpu_pkg::LOAD_ADDR;
			cpu_pkg::EX_NOOP: next_state = cpu_pkg::INC_RIP;
			cpu_pkg::EX_JUMP: if (step == 2) next_state = cpu_pkg::FETCH;
			cpu_pkg::EX_MATH: if (step == 2) next_state = cpu_pkg::INC_RIP;
			cpu_pkg::EX_LDFI, cpu_pkg::EX_CPFR: if (step == 3) next_state = cpu_pkg::INC_RIP;
			cpu_pkg::EX_STOM: if (step == 4) next_state = cpu_pkg::INC_RIP;
			cpu_pkg::EX_LDFM: if (step == 5) next_state = cpu_pkg::INC_RIP;
			cpu_pkg::EX_JINZ, cpu_pkg::EX_JIEQ, cpu_pkg::EX_JILT, cpu_pkg::EX_JIGT: begin
				if (step == 0 && !jump_taken) begin
					next_state = cpu_pkg::INC_RIP;
				end else if (step == 2) begin
					next_state = cpu_pkg::FETCH;
				end
			end
			default: next_state = cpu_pkg::LOAD_ADDR;
		endcase
	end

	always_comb begin
		o_ctrl = '0;
		o_ctrl.sel = cpu_pkg::D_IN;
		o_waiting = 1'b0;
		latch_code = 1'b0;
		load_target = 1'b0;
		case (state)
			cpu_pkg::LOAD_ADDR: begin
				o_ctrl.load_addr = 1'b1;
				o_waiting = 1'b1;
			end
			cpu_pkg::LOAD_DATA: o_ctrl.write_ram = 1'b1;
			cpu_pkg::PRE_EXECUTE: begin
				o_ctrl.sel = cpu_pkg::ZERO;
				o_ctrl.load_rip = 1'b1;
				o_ctrl.load_addr = 1'b1;
			end
			cpu_pkg::FETCH: begin
				if (step == 0) begin
					o_ctrl.sel = cpu_pkg::RIP;
					o_ctrl.load_addr = 1'b1;
				end
			end
			cpu_pkg::INC_RIP, cpu_pkg::EX_MATH: begin
				if (step == 0) begin
					o_ctrl.sel = cpu_pkg::RIP_1;
					o_ctrl.load_rip = 1'b1;
					o_ctrl.load_addr = 1'b1;
				end else if (step == 2 && state == cpu_pkg::EX_MATH) begin
					// Operation byte comes straight from RAM
					o_ctrl.load_alu = 1'b1;
				end
			end
			cpu_pkg::EX_JUMP, cpu_pkg::EX_JINZ, cpu_pkg::EX_JIEQ, cpu_pkg::EX_JILT,
			cpu_pkg::EX_JIGT: begin
				if (step == 0) begin
					o_ctrl.sel = cpu_pkg::RIP_1;
					o_ctrl.load_addr = 1'b1;
					// Not-taken branches leave RIP on the operand
					o_ctrl.load_rip = (state != cpu_pkg::EX_JUMP);
				end else if (step == 2) begin
					o_ctrl.sel = cpu_pkg::RAM;
					o_ctrl.load_rip = 1'b1;
				end
			end
			cpu_pkg::EX_LDFM, cpu_pkg::EX_LDFI, cpu_pkg::EX_CPFR, cpu_pkg::EX_STOM: begin
				case (step)
					// Step RIP over both operands, second one reads during step 1
					3'd0, 3'd1: begin
						o_ctrl.sel = cpu_pkg::RIP_1;
						o_ctrl.load_rip = 1'b1;
						o_ctrl.load_addr = 1'b1;
					end
					3'd2: latch_code = 1'b1;
					3'd3: begin
						if (state == cpu_pkg::EX_CPFR) begin
							o_ctrl.sel = to_sel(i_ram_word);
							load_target = 1'b1;
						end else begin
							o_ctrl.sel = cpu_pkg::RAM;
							o_ctrl.load_addr = (state != cpu_pkg::EX_LDFI);
							load_target = (state == cpu_pkg::EX_LDFI);
						end
					end
					3'd4: begin
						if (state == cpu_pkg::EX_STOM) begin
							o_ctrl.sel = to_sel(reg_code);
							o_ctrl.write_ram = 1'b1;
						end
					end
					3'd5: begin
						o_ctrl.sel = cpu_pkg::RAM;
						load_target = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase

		// Target code to one-hot load bits, RAX at code 9
		if (load_target) begin
			if (reg_code < `CPU_NUM_REGS) begin
				o_ctrl.load_reg[reg_code[2:0]] = 1'b1;
			end else if (reg_code == 8'(cpu_pkg::RAX)) begin
				o_ctrl.load_rax = 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state <= cpu_pkg::LOAD_ADDR;
			step <= '0;
			reg_code <= '0;
		end else begin
			state <= next_state;
			if (next_state != state) begin
				step <= '0;
			end else if (step != '1) begin
				// Hold at the top so step 0 actions never repeat
				step <= step + 1'b1;
			end
			if (latch_code) reg_code <= i_ram_word;
		end
	end

	a_load_reg_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
		$onehot0(o_ctrl.load_reg))
		else $error("sequencer: more than one register load at once");

	a_alu_rax_excl: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_ctrl.load_alu && o_ctrl.load_rax))
		else $error("sequencer: ALU and bus both load RAX");

endmodule

//--- tb/tb_clock.sv
module tb_clock (
	output logic o_clk,
	output logic o_reset
);

	// Period of 100 time units
	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;
	end

	// Reset covers the first four rising edges
	initial begin
		o_reset = 1'b1;
		repeat (4) @(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

//--- tb/tb_cpu.sv
`include "cpu_params.svh"

module tb_cpu;
	// About 310 loaded bytes at 11 cycles each, 150 instructions and 30 reads
	localparam int MAX_CYCLES = 20000;
	localparam int MODEL_STEPS = 200;

	logic i_clk;
	logic i_reset;
	logic i_load_addr;
	logic i_load_data;
	logic i_execute;
	cpu_pkg::byte_t i_data_in;
	cpu_pkg::byte_t o_data_out;
	logic o_waiting;

	integer seed = 32'h2fe436b5;
	int cycles = 0;
	cpu_pkg::addr_t pc;
	cpu_pkg::addr_t load_q[$];
	cpu_pkg::addr_t check_q[$];

	// Reference machine, kept across programs like the DUT
	cpu_pkg::byte_t model_mem [`CPU_MEM_DEPTH];
	cpu_pkg::byte_t m_regs [`CPU_NUM_REGS];
	cpu_pkg::byte_t m_rax;
	cpu_pkg::flags_t m_rfl;

	tb_clock u_clock (
		.o_clk(i_clk),
		.o_reset(i_reset)
	);

	cpu i_cpu (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_load_addr(i_load_addr),
		.i_load_data(i_load_data),
		.i_execute(i_execute),
		.i_data_in(i_data_in),
		.o_data_out(o_data_out),
		.o_waiting(o_waiting)
	);

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "stopped at the first failure");
	endtask

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("run exceeded %0d clock cycles", MAX_CYCLES);
			abort_run();
		end
	end

	task automatic check_byte(input cpu_pkg::addr_t addr, input cpu_pkg::byte_t got,
			input cpu_pkg::byte_t exp);
		if (got !== exp) begin
			$display("error: o_data_out at address 0x%h is 0x%h, expected 0x%h", addr, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error: %s is 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic cpu_pkg::byte_t random_byte();
		return cpu_pkg::byte_t'($random(seed));
	endfunction

	function automatic int ins_len(input cpu_pkg::byte_t op);
		case (op)
			cpu_pkg::JUMP, cpu_pkg::MATH, cpu_pkg::JINZ, cpu_pkg::JIEQ,
			cpu_pkg::JILT, cpu_pkg::JIGT: return 2;
			cpu_pkg::LDFI, cpu_pkg::LDFM, cpu_pkg::CPFR, cpu_pkg::STOM: return 3;
			default: return 1;
		endcase
	endfunction

	function automatic cpu_pkg::byte_t read_reg(input cpu_pkg::byte_t code);
		if (code < 8'd8) return m_regs[code[2:0]];
		if (code == 8'd9) return m_rax;
		if (code == 8'd10) return cpu_pkg::byte_t'(m_rfl);
		return '0;
	endfunction

	// Codes other than REG0 to REG7 and RAX load nothing
	function automatic void write_reg(input cpu_pkg::byte_t code, input cpu_pkg::byte_t v);
		if (code < 8'd8) begin
			m_regs[code[2:0]] = v;
		end else if (code == 8'd9) begin
			m_rax = v;
		end
	endfunction

	function automatic void apply_math(input cpu_pkg::byte_t opb);
		cpu_pkg::byte_t a;
		cpu_pkg::byte_t b;
		cpu_pkg::byte_t res;
		logic carry;
		logic known;
		a = m_rax;
		b = m_regs[0];
		res = '0;
		carry = 1'b0;
		// Bit 7 is the old sign select and has no effect
		known = (opb[6:3] == 4'd0);
		case (opb[2:0])
			cpu_pkg::ADD: {carry, res} = {1'b0, a} + {1'b0, b};
			cpu_pkg::SUB: begin
				res = a - b;
				carry = (a < b);
			end
			cpu_pkg::AND: res = a & b;
			cpu_pkg::OR: res = a | b;
			cpu_pkg::XOR: res = a ^ b;
			cpu_pkg::PASS_B: res = b;
			default: known = 1'b0;
		endcase
		if (!known) begin
			res = '0;
			carry = 1'b0;
		end
		m_rax = res;
		m_rfl = '0;
		m_rfl.carry = carry;
		m_rfl.equal = (a == b);
		m_rfl.less_than = (a < b);
		m_rfl.zero = (res == 8'd0);
		m_rfl.undefined = !known;
	endfunction

	// Interprets the program in model_mem, returns the instruction count
	function automatic int run_model();
		cpu_pkg::byte_t rip;
		cpu_pkg::byte_t op;
		cpu_pkg::byte_t x;
		cpu_pkg::byte_t y;
		logic taken;
		int count;
		rip = '0;
		count = 0;
		while (count < MODEL_STEPS) begin
			op = model_mem[rip];
			x = model_mem[rip + 8'd1];
			y = model_mem[rip + 8'd2];
			count++;
			taken = 1'b0;
			case (op)
				cpu_pkg::NOOP: ;
				cpu_pkg::JUMP: taken = 1'b1;
				cpu_pkg::MATH: apply_math(x);
				cpu_pkg::LDFI: write_reg(x, y);
				cpu_pkg::LDFM: write_reg(x, model_mem[y]);
				cpu_pkg::CPFR: write_reg(x, read_reg(y));
				cpu_pkg::STOM: model_mem[y] = read_reg(x);
				cpu_pkg::JINZ: taken = !m_rfl.zero;
				cpu_pkg::JIEQ: taken = m_rfl.equal;
				cpu_pkg::JILT: taken = m_rfl.less_than;
				cpu_pkg::JIGT: taken = !(m_rfl.equal || m_rfl.less_than);
				// HALT and unknown opcodes
				default: return count;
			endcase
			if (taken) begin
				rip = x;
			end else begin
				rip = rip + cpu_pkg::byte_t'(ins_len(op));
			end
		end
		return count;
	endfunction

	task automatic step_clock(input int n);
		repeat (n) @(posedge i_clk);
	endtask

	task automatic put_word(input cpu_pkg::addr_t a, input cpu_pkg::byte_t v);
		model_mem[a] = v;
		load_q.push_back(a);
	endtask

	// Preset a result word so that a missing store shows up
	task automatic watch_word(input cpu_pkg::addr_t a);
		put_word(a, {a[3:0], a[7:4]} ^ 8'h96);
		check_q.push_back(a);
	endtask

	task automatic emit(input cpu_pkg::byte_t b);
		put_word(pc, b);
		pc = pc + 8'd1;
	endtask

	task automatic ins(input cpu_pkg::byte_t op, input cpu_pkg::byte_t x,
			input cpu_pkg::byte_t y);
		int n;
		n = ins_len(op);
		emit(op);
		if (n > 1) emit(x);
		if (n > 2) emit(y);
	endtask

	task automatic load_byte(input cpu_pkg::addr_t a, input cpu_pkg::byte_t v);
		step_clock(1);
		i_data_in <= a;
		step_clock(2);
		i_load_addr <= 1'b1;
		step_clock(2);
		i_load_addr <= 1'b0;
		i_data_in <= v;
		step_clock(2);
		i_load_data <= 1'b1;
		step_clock(2);
		i_load_data <= 1'b0;
		step_clock(2);
	endtask

	task automatic load_program();
		cpu_pkg::addr_t a;
		while (load_q.size() > 0) begin
			a = load_q.pop_front();
			load_byte(a, model_mem[a]);
		end
	endtask

	task automatic read_word(input cpu_pkg::addr_t a);
		step_clock(1);
		i_data_in <= a;
		step_clock(3);
		@(negedge i_clk);
		check_byte(a, o_data_out, model_mem[a]);
	endtask

	task automatic check_all();
		while (check_q.size() > 0) begin
			read_word(check_q.pop_front());
		end
	endtask

	task automatic execute_program();
		int limit;
		int waited;
		// LDFM with its fetch is the longest instruction at nine cycles
		limit = run_model() * 10 + 32;
		step_clock(1);
		i_execute <= 1'b1;
		step_clock(2);
		i_execute <= 1'b0;
		waited = 0;
		@(negedge i_clk);
		while (!o_waiting && waited < limit) begin
			@(negedge i_clk);
			waited++;
		end
		if (!o_waiting) begin
			$display("CPU did not return to the load state within %0d cycles", limit);
			abort_run();
		end
	endtask

	task automatic load_run_check();
		load_program();
		execute_program();
		check_all();
	endtask

	initial begin
		cpu_pkg::addr_t a;
		cpu_pkg::byte_t ra;
		cpu_pkg::byte_t rb;
		i_load_addr = 1'b0;
		i_load_data = 1'b0;
		i_execute = 1'b0;
		i_data_in = '0;
		m_rax = '0;
		m_rfl = '0;
		foreach (m_regs[i]) m_regs[i] = '0;
		wait (i_reset == 1'b0);
		@(negedge i_clk);
		check_flag("o_waiting", o_waiting, 1'b1);

		// Plain load and read-back in the upper quarter
		for (int k = 0; k < 8; k++) begin
			a = random_byte() | 8'hc0;
			put_word(a, random_byte());
			check_q.push_back(a);
		end
		load_program();
		check_all();

		// Immediates stored through REG3, RAX and REG7
		pc = '0;
		watch_word(8'h80);
		watch_word(8'h81);
		watch_word(8'h82);
		ins(cpu_pkg::LDFI, 8'd3, random_byte());
		ins(cpu_pkg::STOM, 8'd3, 8'h80);
		ins(cpu_pkg::LDFI, 8'd9, random_byte());
		ins(cpu_pkg::STOM, 8'd9, 8'h81);
		ins(cpu_pkg::LDFI, 8'd7, random_byte());
		ins(cpu_pkg::STOM, 8'd7, 8'h82);
		ins(cpu_pkg::HALT, 8'd0, 8'd0);
		load_run_check();

		// Every ALU operation plus one unknown code
		pc = '0;
		for (int k = 0; k < 7; k++) begin
			a = cpu_pkg::addr_t'(8'h84 + 2 * k);
			ra = random_byte();
			rb = (k == 4) ? ra : random_byte();
			watch_word(a);
			watch_word(a + 8'd1);
			ins(cpu_pkg::LDFI, 8'd9, ra);
			ins(cpu_pkg::LDFI, 8'd0, rb);
			ins(cpu_pkg::MATH, cpu_pkg::byte_t'(k) | (k[0] ? 8'h80 : 8'h00), 8'd0);
			ins(cpu_pkg::STOM, 8'd9, a);
			ins(cpu_pkg::CPFR, 8'd1, 8'd10);
			ins(cpu_pkg::STOM, 8'd1, a + 8'd1);
		end
		ins(cpu_pkg::HALT, 8'd0, 8'd0);
		load_run_check();

		// Branches after below, equal and above compares
		pc = '0;
		ins(cpu_pkg::LDFI, 8'd3, 8'hee);
		for (int c = 0; c < 3; c++) begin
			rb = (random_byte() & 8'h3f) | 8'h20;
			if (c == 0) begin
				ra = rb - 8'h10;
			end else if (c == 1) begin
				ra = rb;
			end else begin
				ra = rb + 8'h40;
			end
			ins(cpu_pkg::LDFI, 8'd9, ra);
			ins(cpu_pkg::LDFI, 8'd0, rb);
			ins(cpu_pkg::MATH, 8'd1, 8'd0);
			for (int j = 0; j < 4; j++) begin
				a = cpu_pkg::addr_t'(8'h98 + 4 * c + j);
				watch_word(a);
				// Marker written only on the fall-through path
				ins(cpu_pkg::byte_t'(8'h0a + j), pc + 8'd5, 8'd0);
				ins(cpu_pkg::STOM, 8'd3, a);
			end
		end
		ins(cpu_pkg::HALT, 8'd0, 8'd0);
		load_run_check();

		// Memory through registers, then a skipped store
		pc = '0;
		put_word(8'ha8, random_byte());
		check_q.push_back(8'ha8);
		watch_word(8'ha9);
		watch_word(8'haa);
		watch_word(8'hab);
		ins(cpu_pkg::LDFM, 8'd4, 8'ha8);
		ins(cpu_pkg::NOOP, 8'd0, 8'd0);
		ins(cpu_pkg::CPFR, 8'd5, 8'd4);
		ins(cpu_pkg::CPFR, 8'd6, 8'd5);
		ins(cpu_pkg::STOM, 8'd6, 8'ha9);
		ins(cpu_pkg::CPFR, 8'd9, 8'd6);
		ins(cpu_pkg::STOM, 8'd9, 8'hab);
		ins(cpu_pkg::JUMP, pc + 8'd5, 8'd0);
		ins(cpu_pkg::STOM, 8'd4, 8'haa);
		ins(cpu_pkg::HALT, 8'd0, 8'd0);
		load_run_check();

		// Opcode 0x02 is not defined and stops the run
		pc = '0;
		watch_word(8'hb0);
		watch_word(8'hb1);
		ins(cpu_pkg::LDFI, 8'd2, random_byte());
		ins(cpu_pkg::STOM, 8'd2, 8'hb0);
		emit(8'h02);
		ins(cpu_pkg::STOM, 8'd2, 8'hb1);
		ins(cpu_pkg::HALT, 8'd0, 8'd0);
		load_run_check();
		@(negedge i_clk);
		check_flag("o_waiting", o_waiting, 1'b1);

		$display("Regression passed");
		$finish;
	end

endmodule
